//--- Makefile
# Verilator build and run for the two-channel DMA controller

VERILATOR ?= verilator
TB_TOP    ?= tb_dma_top
RTL_TOP   ?= dma_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := TESTBENCH PASSED

RTL_SRCS := source/dma_pkg.sv source/dma_apb_regs.sv source/dma_req_capture.sv \
            source/dma_ahb_engine.sv source/dma_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
source/dma_pkg.sv
source/dma_apb_regs.sv
source/dma_req_capture.sv
source/dma_ahb_engine.sv
source/dma_top.sv
verif/tb_dma_mem.sv
verif/tb_dma_top.sv

//--- source/dma_ahb_engine.sv
//------------------------------------------------------------
// DMA AHB-Lite engine
// Fixed-priority arbitration between channels and a word
// copy FSM. Each word is a single read then a single write,
// one transfer on the bus at a time
//------------------------------------------------------------
`timescale 1ns/1ps

module dma_ahb_engine (
    input  logic                                   HCLK,
    input  logic                                   rst_n,
    input  dma_pkg::ch_vec_t                       pending,
    input  dma_pkg::ch_cfg_t [dma_pkg::CH_NUM-1:0] cfg,
    input  dma_pkg::ahb_rsp_t                      ahb_rsp,
    output dma_pkg::ch_vec_t                       grant,
    output dma_pkg::ahb_req_t                      ahb_req,
    output dma_pkg::ch_vec_t                       ch_done,
    output dma_pkg::ch_vec_t                       ch_fail
);

    dma_pkg::eng_state_e state_q;
    dma_pkg::ch_idx_t    sel_ch;
    dma_pkg::ch_idx_t    cur_ch;
    dma_pkg::addr_t      src_q;
    dma_pkg::addr_t      dst_q;
    dma_pkg::len_t       cnt_q;
    dma_pkg::data_t      data_q;
    logic                start;
    logic                rd_ok;
    logic                wr_ok;
    logic                last;
    logic                is_wr;

    //------------------------------------------------------------
    // Arbitration, lowest pending channel wins
    always_comb begin
        sel_ch = '0;
        for (int i = dma_pkg::CH_NUM - 1; i >= 0; i--) begin
            if (pending[i]) begin
                sel_ch = dma_pkg::ch_idx_t'(i);
            end
        end
    end

    assign start = (state_q == dma_pkg::IDLE) && (|pending);
    assign grant = start ? (dma_pkg::ch_vec_t'(1) << sel_ch) : '0;

    // Data phase ends
    assign rd_ok = (state_q == dma_pkg::RD_DATA) && ahb_rsp.hready && !ahb_rsp.hresp;
    assign wr_ok = (state_q == dma_pkg::WR_DATA) && ahb_rsp.hready && !ahb_rsp.hresp;
    assign last  = (cnt_q == dma_pkg::len_t'(1));

    //------------------------------------------------------------
    // Copy FSM
    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= dma_pkg::IDLE;
            cur_ch  <= '0;
            cnt_q   <= '0;
            ch_done <= '0;
            ch_fail <= '0;
        end else begin
            ch_done <= '0;                       // Single-cycle pulses
            ch_fail <= '0;
            case (state_q)
                dma_pkg::IDLE: begin
                    if (start) begin
                        cur_ch <= sel_ch;
                        cnt_q  <= cfg[sel_ch].len;
                        if (cfg[sel_ch].len == '0) begin
                            ch_done[sel_ch] <= 1'b1;   // Nothing to move
                        end else begin
                            state_q <= dma_pkg::RD_ADDR;
                        end
                    end
                end
                dma_pkg::RD_ADDR: begin
                    if (ahb_rsp.hready) begin
                        state_q <= dma_pkg::RD_DATA;
                    end
                end
                dma_pkg::RD_DATA: begin
                    if (ahb_rsp.hready) begin
                        if (ahb_rsp.hresp) begin
                            ch_fail[cur_ch] <= 1'b1;
                            state_q         <= dma_pkg::IDLE;
                        end else begin
                            state_q <= dma_pkg::WR_ADDR;
                        end
                    end
                end
                dma_pkg::WR_ADDR: begin
                    if (ahb_rsp.hready) begin
                        state_q <= dma_pkg::WR_DATA;
                    end
                end
                dma_pkg::WR_DATA: begin
                    if (ahb_rsp.hready && ahb_rsp.hresp) begin
                        ch_fail[cur_ch] <= 1'b1;
                        state_q         <= dma_pkg::IDLE;
                    end else if (wr_ok && last) begin
                        ch_done[cur_ch] <= 1'b1;
                        state_q         <= dma_pkg::IDLE;
                    end else if (wr_ok) begin
                        cnt_q   <= cnt_q - dma_pkg::len_t'(1);
                        state_q <= dma_pkg::RD_ADDR;
                    end
                end
                default: state_q <= dma_pkg::IDLE;
            endcase
        end
    end

    // Addresses and the word in flight
    always_ff @(posedge HCLK) begin
        if (start) begin
            src_q <= cfg[sel_ch].src;
            dst_q <= cfg[sel_ch].dst;
        end else if (wr_ok && !last) begin
            src_q <= src_q + dma_pkg::addr_t'(dma_pkg::DATA_W / 8);
            dst_q <= dst_q + dma_pkg::addr_t'(dma_pkg::DATA_W / 8);
        end
        if (rd_ok) begin
            data_q <= ahb_rsp.hrdata;
        end
    end

    //------------------------------------------------------------
    // AHB-Lite master outputs
    assign is_wr = (state_q == dma_pkg::WR_ADDR) || (state_q == dma_pkg::WR_DATA);

    always_comb begin
        ahb_req.haddr  = is_wr ? dst_q : src_q;
        ahb_req.hwrite = is_wr;
        ahb_req.hsize  = dma_pkg::HSIZE_WORD;
        ahb_req.hwdata = data_q;                 // Stable through the write data phase
        if (state_q == dma_pkg::RD_ADDR || state_q == dma_pkg::WR_ADDR) begin
            ahb_req.htrans = dma_pkg::HTRANS_NONSEQ;
        end else begin
            ahb_req.htrans = dma_pkg::HTRANS_IDLE;
        end
    end

    a_htrans_legal: assert property (@(posedge HCLK) disable iff (!rst_n)
        ahb_req.htrans == dma_pkg::HTRANS_IDLE || ahb_req.htrans == dma_pkg::HTRANS_NONSEQ);

    // A stalled address phase holds the transfer
    a_addr_hold: assert property (@(posedge HCLK) disable iff (!rst_n)
        (ahb_req.htrans == dma_pkg::HTRANS_NONSEQ && !ahb_rsp.hready)
        |=> (ahb_req.htrans == dma_pkg::HTRANS_NONSEQ && $stable(ahb_req.haddr)
             && $stable(ahb_req.hwrite)));

endmodule

//--- source/dma_apb_regs.sv
//------------------------------------------------------------
// DMA APB register file
// Per-channel source, destination, word count, enable and
// sticky error. Zero wait states, pslverr outside the map
//------------------------------------------------------------
`timescale 1ns/1ps

module dma_apb_regs (
    input  logic                                   HCLK,
    input  logic                                   rst_n,
    input  logic                                   pclken,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  dma_pkg::cfg_addr_t                     paddr,
    input  dma_pkg::data_t                         pwdata,
    input  dma_pkg::ch_vec_t                       ch_done,
    input  dma_pkg::ch_vec_t                       ch_fail,
    output dma_pkg::data_t                         prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    output dma_pkg::ch_cfg_t [dma_pkg::CH_NUM-1:0] cfg,
    output dma_pkg::ch_vec_t                       ch_en,
    output logic                                   dma_err
);

    logic                                                  access;
    logic                                                  wr_en;
    logic [dma_pkg::CFG_ADDR_W-dma_pkg::REG_OFS_W-1:0]     win;
    logic [dma_pkg::REG_OFS_W-1:0]                         ofs;
    dma_pkg::ch_vec_t                                      hit;
    dma_pkg::ch_idx_t                                      rd_ch;
    dma_pkg::ch_vec_t                                      err_q;

    assign access = psel & penable & pclken;
    assign wr_en  = access & pwrite;
    assign win    = paddr[dma_pkg::CFG_ADDR_W-1:dma_pkg::REG_OFS_W];
    assign ofs    = paddr[dma_pkg::REG_OFS_W-1:0];
    assign rd_ch  = win[dma_pkg::CH_IDX_W-1:0];

    // Channel window decode
    always_comb begin
        for (int i = 0; i < dma_pkg::CH_NUM; i++) begin
            hit[i] = (win == (dma_pkg::CFG_ADDR_W - dma_pkg::REG_OFS_W)'(i));
        end
    end

    assign pready  = 1'b1;                       // Never stalls
    assign pslverr = access & ~(|hit);
    assign dma_err = |err_q;

    //------------------------------------------------------------
    // Read mux
    always_comb begin
        prdata = '0;
        if (|hit) begin
            case (ofs)
                dma_pkg::REG_CTRL: begin
                    prdata[dma_pkg::CTRL_EN_BIT]  = ch_en[rd_ch];
                    prdata[dma_pkg::CTRL_ERR_BIT] = err_q[rd_ch];
                end
                dma_pkg::REG_SRC: prdata = cfg[rd_ch].src;
                dma_pkg::REG_DST: prdata = cfg[rd_ch].dst;
                dma_pkg::REG_LEN: prdata = dma_pkg::data_t'(cfg[rd_ch].len);
                default:          prdata = '0;   // Unaligned offsets read zero
            endcase
        end
    end

    //------------------------------------------------------------
    // Register writes, engine events override software
    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            cfg   <= '0;
            ch_en <= '0;
            err_q <= '0;
        end else begin
            for (int i = 0; i < dma_pkg::CH_NUM; i++) begin
                if (wr_en && hit[i]) begin
                    case (ofs)
                        dma_pkg::REG_CTRL: begin
                            ch_en[i] <= pwdata[dma_pkg::CTRL_EN_BIT];
                            err_q[i] <= 1'b0;
                        end
                        dma_pkg::REG_SRC: cfg[i].src <= pwdata;
                        dma_pkg::REG_DST: cfg[i].dst <= pwdata;
                        dma_pkg::REG_LEN: cfg[i].len <= pwdata[dma_pkg::LEN_W-1:0];
                        default: ;
                    endcase
                end
                if (ch_done[i] || ch_fail[i]) begin
                    ch_en[i] <= 1'b0;            // Channel disables itself
                end
                if (ch_fail[i]) begin
                    err_q[i] <= 1'b1;
                end
            end
        end
    end

    // A copy ends either well or badly, never both
    a_done_xor_fail: assert property (@(posedge HCLK) disable iff (!rst_n)
        (ch_done & ch_fail) == '0);

endmodule

//--- source/dma_pkg.sv
//------------------------------------------------------------
// DMA package
// Widths, APB register map, AHB-Lite codes, bus structs and
// engine states for the two-channel DMA controller
//------------------------------------------------------------
package dma_pkg;

    //------------------------------------------------------------
    // Sizes
    localparam int CH_NUM     = 2;
    localparam int CH_IDX_W   = $clog2(CH_NUM);
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int CFG_ADDR_W = 13;              // APB address width
    localparam int LEN_W      = 16;              // Word count width

    //------------------------------------------------------------
    // Register map, one 16-byte window per channel
    localparam int CH_STRIDE = 'h10;
    localparam int REG_OFS_W = $clog2(CH_STRIDE);
    localparam logic [REG_OFS_W-1:0] REG_CTRL = 'h0;
    localparam logic [REG_OFS_W-1:0] REG_SRC  = 'h4;
    localparam logic [REG_OFS_W-1:0] REG_DST  = 'h8;
    localparam logic [REG_OFS_W-1:0] REG_LEN  = 'hC;
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_ERR_BIT = 1;             // Sticky, cleared by a CTRL write

    // AHB-Lite codes
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [2:0] HSIZE_WORD    = 3'b010;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
    typedef logic [LEN_W-1:0]      len_t;
    typedef logic [CH_NUM-1:0]     ch_vec_t;
    typedef logic [CH_IDX_W-1:0]   ch_idx_t;

    typedef struct packed {
        addr_t src;
        addr_t dst;
        len_t  len;
    } ch_cfg_t;

    typedef struct packed {
        addr_t      haddr;
        logic [1:0] htrans;
        logic       hwrite;
        logic [2:0] hsize;
        data_t      hwdata;
    } ahb_req_t;

    typedef struct packed {
        data_t hrdata;
        logic  hready;
        logic  hresp;
    } ahb_rsp_t;

    typedef enum logic [2:0] {IDLE, RD_ADDR, RD_DATA, WR_ADDR, WR_DATA} eng_state_e;

endpackage

//--- source/dma_req_capture.sv
//------------------------------------------------------------
// DMA request capture
// Turns rising edges on the request lines of enabled
// channels into pending flags, cleared by the engine grant
//------------------------------------------------------------
`timescale 1ns/1ps

module dma_req_capture (
    input  logic             HCLK,
    input  logic             rst_n,
    input  dma_pkg::ch_vec_t dma_req,
    input  dma_pkg::ch_vec_t ch_en,
    input  dma_pkg::ch_vec_t grant,
    output dma_pkg::ch_vec_t pending
);

    dma_pkg::ch_vec_t req_q;
    dma_pkg::ch_vec_t req_rise;

    // Only an enabled channel takes a new edge
    assign req_rise = dma_req & ~req_q & ch_en;

    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= '0;
        end else begin
            req_q <= dma_req;                    // Previous level
        end
    end

    //------------------------------------------------------------
    // Pending flags
    // A granted or disabled channel drops its flag
    // A fresh edge in the same cycle still wins
    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~grant & ch_en) | req_rise;
        end
    end

    // Engine picks only from channels flagged here
    a_grant_pending: assert property (@(posedge HCLK) disable iff (!rst_n)
        (grant & ~pending) == '0);

endmodule

//--- source/dma_top.sv
//------------------------------------------------------------
// Two-channel DMA controller
// APB configuration, per-channel request lines and a single
// shared AHB-Lite master port
//------------------------------------------------------------
`timescale 1ns/1ps

module dma_top (
    input  logic               HCLK,
    input  logic               rst_n,
    // APB configuration port
    input  logic               pclken,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  dma_pkg::cfg_addr_t paddr,
    input  dma_pkg::data_t     pwdata,
    output dma_pkg::data_t     prdata,
    output logic               pready,
    output logic               pslverr,
    // AHB-Lite master
    output dma_pkg::ahb_req_t  ahb_req,
    input  dma_pkg::ahb_rsp_t  ahb_rsp,
    // Requests and status
    input  dma_pkg::ch_vec_t   dma_req,
    output dma_pkg::ch_vec_t   dma_done,             // Equals engine ch_done
    output logic               dma_err
);

    dma_pkg::ch_cfg_t [dma_pkg::CH_NUM-1:0] cfg;
    dma_pkg::ch_vec_t                       ch_en;
    dma_pkg::ch_vec_t                       ch_fail;
    dma_pkg::ch_vec_t                       pending;
    dma_pkg::ch_vec_t                       grant;

    //------------------------------------------------------------
    // Register file
    dma_apb_regs u_regs (
        .HCLK    (HCLK),
        .rst_n   (rst_n),
        .pclken  (pclken),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .ch_done (dma_done),
        .ch_fail (ch_fail),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg),
        .ch_en   (ch_en),
        .dma_err (dma_err)
    );

    // Request edges to pending flags
    dma_req_capture u_req_cap (
        .HCLK    (HCLK),
        .rst_n   (rst_n),
        .dma_req (dma_req),
        .ch_en   (ch_en),
        .grant   (grant),
        .pending (pending)
    );

    //------------------------------------------------------------
    // Copy engine on the shared bus
    dma_ahb_engine u_engine (
        .HCLK    (HCLK),
        .rst_n   (rst_n),
        .pending (pending),
        .cfg     (cfg),
        .ahb_rsp (ahb_rsp),
        .grant   (grant),
        .ahb_req (ahb_req),
        .ch_done (dma_done),
        .ch_fail (ch_fail)
    );

endmodule

//--- verif/tb_dma_mem.sv
//------------------------------------------------------------
// AHB-Lite slave memory for the DMA testbench
// 1024 words with random wait states and a two-cycle error
// response for any address from 0xF00 to 0xFFF
//------------------------------------------------------------
`timescale 1ns/1ps

module tb_dma_mem (
    input  logic              HCLK,
    input  logic              rst_n,
    input  dma_pkg::ahb_req_t ahb_req,
    output dma_pkg::ahb_rsp_t ahb_rsp
);

    localparam int WORDS = 1024;

    dma_pkg::data_t mem [WORDS];
    logic           dph_q;                       // Data phase in progress
    logic           wr_q;
    logic           err_q;
    logic           err_seen_q;                  // First error cycle done
    logic [9:0]     idx_q;
    logic [1:0]     wait_q;
    logic           ready;
    logic           err_addr;

    assign err_addr = (ahb_req.haddr >= 32'hF00) && (ahb_req.haddr <= 32'hFFF);

    // Low during wait states and the first error cycle
    assign ready = !dph_q || (wait_q == '0 && !(err_q && !err_seen_q));

    assign ahb_rsp.hready = ready;
    assign ahb_rsp.hresp  = dph_q && err_q && (wait_q == '0);
    assign ahb_rsp.hrdata = (dph_q && !wr_q) ? mem[idx_q] : '0;

    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            dph_q      <= 1'b0;
            wr_q       <= 1'b0;
            err_q      <= 1'b0;
            err_seen_q <= 1'b0;
            idx_q      <= '0;
            wait_q     <= '0;
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= 32'h5A5A_0000 ^ (32'(i) * 32'h0001_0001);   // Address-based fill
            end
        end else begin
            if (dph_q && ready) begin
                if (wr_q && !err_q) begin
                    mem[idx_q] <= ahb_req.hwdata;
                end
                dph_q <= 1'b0;
            end else if (dph_q && wait_q != '0) begin
                wait_q <= wait_q - 2'd1;
            end else if (dph_q) begin
                err_seen_q <= 1'b1;
            end
            // New address phase
            if (ahb_req.htrans == dma_pkg::HTRANS_NONSEQ && ready) begin
                dph_q      <= 1'b1;
                wr_q       <= ahb_req.hwrite;
                err_q      <= err_addr;
                err_seen_q <= 1'b0;
                idx_q      <= ahb_req.haddr[11:2];
                wait_q     <= 2'($urandom_range(0, 2));
            end
        end
    end

endmodule

//--- verif/tb_dma_top.sv
//------------------------------------------------------------
// DMA controller testbench
// APB register access, random block copies checked against a
// shadow memory, channel priority, ignored requests, bus error
//------------------------------------------------------------
`timescale 1ns/1ps

module tb_dma_top;

    localparam int N_COPY    = 6;                // Random single copies
    localparam int MAX_LEN   = 16;
    localparam int MAX_WORDS = (N_COPY + 4) * MAX_LEN;
    localparam int WDOG_CYC  = 200 * MAX_WORDS + 5000;
    localparam int MEM_WORDS = 1024;

    logic               HCLK;
    logic               rst_n;
    logic               pclken;
    logic               psel;
    logic               penable;
    logic               pwrite;
    dma_pkg::cfg_addr_t paddr;
    dma_pkg::data_t     pwdata;
    dma_pkg::data_t     prdata;
    logic               pready;
    logic               pslverr;
    dma_pkg::ahb_req_t  ahb_req;
    dma_pkg::ahb_rsp_t  ahb_rsp;
    dma_pkg::ch_vec_t   dma_req;
    dma_pkg::ch_vec_t   dma_done;
    logic               dma_err;

    dma_pkg::data_t shadow [MEM_WORDS];          // Reference memory
    int             done_cnt [dma_pkg::CH_NUM];
    int             done_order [$];
    int             errors;
    int             checks;

    dma_top dma_top_i (.*);
    tb_dma_mem mem_i (.*);

    initial begin
        HCLK = 1'b0;
        forever #10 HCLK = ~HCLK;
    end

    // Done pulses counted mid-cycle
    always @(negedge HCLK) begin
        for (int i = 0; i < dma_pkg::CH_NUM; i++) begin
            if (dma_done[i]) begin
                done_cnt[i]++;
                done_order.push_back(i);
            end
        end
    end

    initial begin
        repeat (WDOG_CYC) @(posedge HCLK);
        $display("timeout after %0d cycles, a DMA copy never finished", WDOG_CYC);
        $display("TESTBENCH FAILED");
        $finish;
    end

    //------------------------------------------------------------
    // Helpers
    function automatic dma_pkg::data_t fill_word(input int i);
        return 32'h5A5A_0000 ^ (32'(i) * 32'h0001_0001);
    endfunction

    function automatic dma_pkg::cfg_addr_t reg_addr(input int ch, input int ofs);
        return dma_pkg::cfg_addr_t'(ch * dma_pkg::CH_STRIDE + ofs);
    endfunction

    task automatic check_val(input string name, input dma_pkg::data_t exp,
                             input dma_pkg::data_t act);
        checks++;
        if (act !== exp) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_mem(input string name);
        checks++;
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (mem_i.mem[i] !== shadow[i]) begin
                $display("mismatch %s word %0d expected %h actual %h",
                         name, i, shadow[i], mem_i.mem[i]);
                errors++;
            end
        end
    endtask

    // One APB transfer with read data sampled mid access phase
    task automatic apb_xfer(input logic wr, input dma_pkg::cfg_addr_t addr,
                            input dma_pkg::data_t wdata, output dma_pkg::data_t rdata,
                            output logic err);
        @(posedge HCLK);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge HCLK);
        #2;
        penable = 1'b1;
        #8;
        rdata = prdata;
        err   = pslverr;
        check_val("apb pready", 1, dma_pkg::data_t'(pready));   // Zero wait states
        @(posedge HCLK);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic reg_write(input int ch, input int ofs, input dma_pkg::data_t val);
        dma_pkg::data_t rd;
        logic           err;
        apb_xfer(1'b1, reg_addr(ch, ofs), val, rd, err);
    endtask

    task automatic config_ch(input int ch, input int src_w, input int dst_w,
                             input int len, input logic en);
        reg_write(ch, dma_pkg::REG_SRC, dma_pkg::data_t'(src_w * 4));
        reg_write(ch, dma_pkg::REG_DST, dma_pkg::data_t'(dst_w * 4));
        reg_write(ch, dma_pkg::REG_LEN, dma_pkg::data_t'(len));
        reg_write(ch, dma_pkg::REG_CTRL, dma_pkg::data_t'(en));
    endtask

    task automatic pulse_req(input dma_pkg::ch_vec_t mask);
        @(posedge HCLK);
        #2;
        dma_req = dma_req | mask;
        @(posedge HCLK);
        #2;
        dma_req = dma_req & ~mask;
    endtask

    task automatic wait_done(input int ch, input int target);
        while (done_cnt[ch] < target) begin
            @(posedge HCLK);
        end
    endtask

    task automatic model_copy(input int src_w, input int dst_w, input int len);
        for (int k = 0; k < len; k++) begin
            shadow[dst_w + k] = shadow[src_w + k];
        end
    endtask

    //------------------------------------------------------------
    // Test sequence
    initial begin
        dma_pkg::data_t rd;
        dma_pkg::data_t val;
        logic           err;
        int             ch;
        int             target;
        int             s_w [dma_pkg::CH_NUM];
        int             d_w [dma_pkg::CH_NUM];
        int             l_w [dma_pkg::CH_NUM];

        void'($urandom(24));
        errors  = 0;
        checks  = 0;
        rst_n   = 1'b0;
        pclken  = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        dma_req = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = fill_word(i);
        end
        repeat (4) @(posedge HCLK);
        #2 rst_n = 1'b1;

        // Register readback and unmapped addresses
        for (int c = 0; c < dma_pkg::CH_NUM; c++) begin
            for (int r = 1; r < 4; r++) begin
                val = (r == 3) ? dma_pkg::data_t'($urandom_range(0, 'hFFFF)) : $urandom;
                reg_write(c, 4 * r, val);
                apb_xfer(1'b0, reg_addr(c, 4 * r), '0, rd, err);
                check_val("readback", val, rd);
                check_val("readback pslverr", 0, dma_pkg::data_t'(err));
            end
        end
        for (int k = 0; k < 4; k++) begin
            apb_xfer(1'b0, dma_pkg::cfg_addr_t'($urandom_range(8, 2047) * 4), '0, rd, err);
            check_val("unmapped pslverr", 1, dma_pkg::data_t'(err));
        end

        // Random single copies
        for (int n = 0; n < N_COPY; n++) begin
            ch     = $urandom_range(0, dma_pkg::CH_NUM - 1);
            s_w[0] = $urandom_range(0, 399);
            d_w[0] = $urandom_range(480, 879);
            l_w[0] = $urandom_range(1, MAX_LEN);
            target = done_cnt[ch] + 1;
            config_ch(ch, s_w[0], d_w[0], l_w[0], 1'b1);
            pulse_req(dma_pkg::ch_vec_t'(1) << ch);
            wait_done(ch, target);
            model_copy(s_w[0], d_w[0], l_w[0]);
            check_mem("single copy");
            apb_xfer(1'b0, reg_addr(ch, dma_pkg::REG_CTRL), '0, rd, err);
            check_val("single copy ctrl", 0, rd);
        end

        // Both requests in one cycle with channel 0 first
        for (int c = 0; c < dma_pkg::CH_NUM; c++) begin
            s_w[c] = $urandom_range(c * 200, c * 200 + 183);
            d_w[c] = $urandom_range(480 + c * 220, 663 + c * 220);
            l_w[c] = $urandom_range(1, MAX_LEN);
            config_ch(c, s_w[c], d_w[c], l_w[c], 1'b1);
        end
        done_order.delete();
        target = done_cnt[0] + 1;
        pulse_req('1);
        wait_done(0, target);
        wait_done(1, done_cnt[1] + (done_order.size() > 1 ? 0 : 1));
        check_val("priority first", 0, dma_pkg::data_t'(done_order[0]));
        check_val("priority second", 1, dma_pkg::data_t'(done_order[1]));
        model_copy(s_w[0], d_w[0], l_w[0]);
        model_copy(s_w[1], d_w[1], l_w[1]);
        check_mem("dual copy");

        // Edge on a disabled channel is ignored
        ch     = $urandom_range(0, dma_pkg::CH_NUM - 1);
        target = done_cnt[ch];
        config_ch(ch, $urandom_range(0, 399), $urandom_range(480, 879), 8, 1'b0);
        pulse_req(dma_pkg::ch_vec_t'(1) << ch);
        repeat (200) @(posedge HCLK);
        check_val("disabled done count", target, done_cnt[ch]);
        check_mem("disabled channel");

        // Level held high starts one copy only
        s_w[0] = $urandom_range(0, 399);
        d_w[0] = $urandom_range(480, 879);
        l_w[0] = $urandom_range(1, MAX_LEN);
        target = done_cnt[0] + 1;
        config_ch(0, s_w[0], d_w[0], l_w[0], 1'b1);
        @(posedge HCLK);
        #2 dma_req[0] = 1'b1;
        wait_done(0, target);
        model_copy(s_w[0], d_w[0], l_w[0]);
        reg_write(0, dma_pkg::REG_CTRL, 1);      // Re-enable with the line still high
        repeat (200) @(posedge HCLK);
        check_val("held request done count", target, done_cnt[0]);
        check_mem("held request");
        @(posedge HCLK);
        #2 dma_req[0] = 1'b0;
        reg_write(0, dma_pkg::REG_CTRL, 0);

        // Error response from the bus
        target = done_cnt[1];
        config_ch(1, $urandom_range(960, 1019), $urandom_range(480, 879),
                  $urandom_range(1, 4), 1'b1);
        pulse_req(2'b10);
        while (!dma_err) begin
            @(negedge HCLK);
        end
        repeat (10) @(posedge HCLK);
        check_val("error done count", target, done_cnt[1]);
        apb_xfer(1'b0, reg_addr(1, dma_pkg::REG_CTRL), '0, rd, err);
        check_val("error ctrl", 2, rd);
        check_mem("error copy");
        reg_write(1, dma_pkg::REG_CTRL, 0);
        #8;
        check_val("error cleared", 0, dma_pkg::data_t'(dma_err));

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
